// File: hw/dram_dma_pkg.sv
package dram_dma_pkg;

   // ------------------------------
   // Channel and address widths
   // ------------------------------
   parameter int num_chan = 4;
   parameter int addr_w   = 64;

   typedef logic [addr_w-1:0] addr_t;

   // Scrubber progress as seen by the register block
   typedef enum logic [2:0]
   {
      idle = 3'd0,
      run  = 3'd1,
      done = 3'd2
   } scrb_state_t;

   // ------------------------------
   // Control and status words
   // ------------------------------
   typedef logic [31:0] ctl_word_t;

   parameter int dbg_en_bit  = 31;
   parameter int dbg_sel_lsb = 28;

   parameter logic [19:0] status_sig  = 20'ha1111;
   parameter logic [31:0] id0_default = 32'hf000_1d0f;
   parameter logic [31:0] id1_default = 32'h1d51_fedd;

   typedef struct packed
   {
      logic [19:0]         sig;
      logic [3:0]          ones;
      logic [num_chan-1:0] done;
      logic [num_chan-1:0] ready;
   } status_norm_t;

   // One nibble per channel, channel 3 in the top nibble
   typedef struct packed
   {
      logic        pad;
      scrb_state_t state;
   } status_chan_t;

   typedef struct packed
   {
      status_chan_t [num_chan-1:0] chan;
      logic [3:0]                  zero;
      logic [3:0]                  ones;
      logic [num_chan-1:0]         done;
      logic [num_chan-1:0]         ready;
   } status_dbg_t;

   typedef union packed
   {
      status_norm_t norm;
      status_dbg_t  dbg;
   } status_word_u;

   // ------------------------------
   // DMA read-return path
   // ------------------------------
   parameter int lanes = 8;

   typedef logic [lanes*64-1:0] rdata_t;
   typedef logic [5:0]          id_t;

endpackage

// File: hw/scrub_if.sv
`timescale 1ns/1ns

interface scrub_if;

   logic                      enable;
   dram_dma_pkg::scrb_state_t state;
   dram_dma_pkg::addr_t       addr;
   logic                      done;

   // Sweep engine side
   modport scrubber
   (
      input  enable,
      output state,
      output addr,
      output done
   );

   // Control and status side
   modport regs
   (
      output enable,
      input  state,
      input  addr,
      input  done
   );

endinterface

// File: hw/reset_flr_ctrl.sv
`timescale 1ns/1ns

module reset_flr_ctrl #(
   parameter int rst_stages = 4
)
(
   input  logic clk,
   input  logic sync_rst_n,
   input  logic flr_req,
   output logic blk_rst_n,
   output logic flr_ack
);

   logic [rst_stages-1:0] rst_pipe;
   logic                  flr_req_q;

   // Ones shift in after release, reset clears the whole chain at once
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
         rst_pipe <= '0;
      else
         rst_pipe <= {rst_pipe[rst_stages-2:0], 1'b1};

   assign blk_rst_n = rst_pipe[rst_stages-1];

   // ------------------------------
   // FLR four-phase acknowledge
   // ------------------------------
   always_ff @(posedge clk or negedge blk_rst_n)
      if (!blk_rst_n)
      begin
         flr_req_q <= 1'b0;
         flr_ack   <= 1'b0;
      end
      else
      begin
         flr_req_q <= flr_req;
         if (!flr_ack && flr_req_q)
            flr_ack <= 1'b1;
         else if (flr_ack && !flr_req_q)
            flr_ack <= 1'b0;
      end

endmodule

// File: hw/mem_scrubber.sv
`timescale 1ns/1ns

module mem_scrubber #(
   parameter dram_dma_pkg::addr_t scrb_max_addr         = 64'h1FFF,
   parameter int                  scrb_burst_len_minus1 = 15
)
(
   input  logic                clk,
   input  logic                rst_n,
   scrub_if.scrubber           scrb,
   output dram_dma_pkg::addr_t awaddr,
   output logic                awvalid,
   input  logic                awready
);

   // 64-byte beats
   localparam dram_dma_pkg::addr_t burst_bytes = (scrb_burst_len_minus1 + 1) * 64;

   dram_dma_pkg::scrb_state_t state_q;
   dram_dma_pkg::addr_t       addr_q;
   logic                      aw_take;
   logic                      last_burst;

   assign aw_take    = awvalid && awready;
   assign last_burst = (addr_q + burst_bytes) > scrb_max_addr;

   always_ff @(posedge clk or negedge rst_n)
      if (!rst_n)
      begin
         state_q <= dram_dma_pkg::idle;
         addr_q  <= '0;
      end
      else if (!scrb.enable)
      begin
         // Abort, next enable restarts from address 0
         state_q <= dram_dma_pkg::idle;
         addr_q  <= '0;
      end
      else
      begin
         case (state_q)
            dram_dma_pkg::idle:
               state_q <= dram_dma_pkg::run;
            dram_dma_pkg::run:
               if (aw_take)
               begin
                  addr_q <= addr_q + burst_bytes;
                  if (last_burst)
                     state_q <= dram_dma_pkg::done;
               end
            default:
               state_q <= dram_dma_pkg::done;
         endcase
      end

   // Address is held until the burst is accepted
   assign awvalid = (state_q == dram_dma_pkg::run);
   assign awaddr  = addr_q;

   assign scrb.state = state_q;
   assign scrb.addr  = addr_q;
   assign scrb.done  = (state_q == dram_dma_pkg::done);

endmodule

// File: hw/scrub_ctrl_regs.sv
`timescale 1ns/1ns

module scrub_ctrl_regs
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  dram_dma_pkg::ctl_word_t           ctl0,
   input  logic [dram_dma_pkg::num_chan-1:0] ddr_is_ready,
   scrub_if.regs                             scrb [dram_dma_pkg::num_chan],
   output dram_dma_pkg::status_word_u        status0,
   output logic [31:0]                       id0,
   output logic [31:0]                       id1
);

   localparam int sel_w = $clog2(dram_dma_pkg::num_chan);

   dram_dma_pkg::ctl_word_t           ctl_q;
   logic [dram_dma_pkg::num_chan-1:0] ready_q;
   logic [dram_dma_pkg::num_chan-1:0] chan_done;
   dram_dma_pkg::scrb_state_t         chan_state [dram_dma_pkg::num_chan];
   dram_dma_pkg::addr_t               chan_addr  [dram_dma_pkg::num_chan];
   logic                              dbg_en;
   logic [2:0]                        dbg_sel;
   logic [sel_w-1:0]                  sel_idx;
   dram_dma_pkg::status_word_u        status_nxt;

   always_ff @(posedge clk or negedge rst_n)
      if (!rst_n)
      begin
         ctl_q   <= '0;
         ready_q <= '0;
      end
      else
      begin
         ctl_q   <= ctl0;
         ready_q <= ddr_is_ready;
      end

   // Channel i is enabled by control bit i
   for (genvar i = 0; i < dram_dma_pkg::num_chan; i++)
   begin : g_chan
      assign scrb[i].enable = ctl_q[i];
      assign chan_done[i]   = scrb[i].done;
      assign chan_state[i]  = scrb[i].state;
      assign chan_addr[i]   = scrb[i].addr;
   end

   assign dbg_en  = ctl_q[dram_dma_pkg::dbg_en_bit];
   assign dbg_sel = ctl_q[dram_dma_pkg::dbg_sel_lsb +: 3];
   // Out-of-range select falls back to channel 0
   assign sel_idx = (dbg_sel < dram_dma_pkg::num_chan) ? dbg_sel[sel_w-1:0] : '0;

   // ------------------------------
   // Status word, two views
   // ------------------------------
   always_comb
   begin
      status_nxt = '0;
      if (dbg_en)
      begin
         for (int i = 0; i < dram_dma_pkg::num_chan; i++)
         begin
            status_nxt.dbg.chan[i].pad   = 1'b0;
            status_nxt.dbg.chan[i].state = chan_state[i];
         end
         status_nxt.dbg.zero  = 4'h0;
         status_nxt.dbg.ones  = 4'hf;
         status_nxt.dbg.done  = chan_done;
         status_nxt.dbg.ready = ready_q;
      end
      else
      begin
         status_nxt.norm.sig   = dram_dma_pkg::status_sig;
         status_nxt.norm.ones  = 4'hf;
         status_nxt.norm.done  = chan_done;
         status_nxt.norm.ready = ready_q;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
      if (!rst_n)
      begin
         status0 <= '0;
         id0     <= '0;
         id1     <= '0;
      end
      else
      begin
         status0 <= status_nxt;
         id0     <= dbg_en ? chan_addr[sel_idx][31:0]  : dram_dma_pkg::id0_default;
         id1     <= dbg_en ? chan_addr[sel_idx][63:32] : dram_dma_pkg::id1_default;
      end

endmodule

// File: hw/rdata_lane_mult.sv
`timescale 1ns/1ns

module rdata_lane_mult
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   input  dram_dma_pkg::rdata_t in_data,
   input  dram_dma_pkg::id_t    in_id,
   input  logic                 in_last,
   output logic                 in_ready,
   output logic                 out_valid,
   output dram_dma_pkg::rdata_t out_data,
   output dram_dma_pkg::id_t    out_id,
   output logic                 out_last,
   input  logic                 out_ready
);

   dram_dma_pkg::rdata_t prod;
   logic                 load;

   // Upper half times lower half, full 64-bit product per lane
   always_comb
      for (int i = 0; i < dram_dma_pkg::lanes; i++)
         prod[i*64 +: 64] = 64'(in_data[i*64+32 +: 32]) * 64'(in_data[i*64 +: 32]);

   // Stage accepts when empty or when its word leaves this cycle
   assign in_ready = !out_valid || out_ready;
   assign load     = in_valid && in_ready;

   always_ff @(posedge clk or negedge rst_n)
      if (!rst_n)
         out_valid <= 1'b0;
      else if (in_ready)
         out_valid <= in_valid;

   always_ff @(posedge clk)
      if (load)
      begin
         out_data <= prod;
         out_id   <= in_id;
         out_last <= in_last;
      end

endmodule

// File: hw/dram_dma_top.sv
`timescale 1ns/1ns

module dram_dma_top #(
   parameter int                  rst_stages            = 4,
   parameter dram_dma_pkg::addr_t scrb_max_addr         = 64'h1FFF,
   parameter int                  scrb_burst_len_minus1 = 15
)
(
   input  logic                              clk,
   input  logic                              sync_rst_n,

   input  logic                              flr_req,
   output logic                              flr_ack,

   input  dram_dma_pkg::ctl_word_t           ctl0,
   input  logic [dram_dma_pkg::num_chan-1:0] ddr_is_ready,
   output dram_dma_pkg::status_word_u        status0,
   output logic [31:0]                       id0,
   output logic [31:0]                       id1,

   output dram_dma_pkg::addr_t               scrb_awaddr [dram_dma_pkg::num_chan],
   output logic [dram_dma_pkg::num_chan-1:0] scrb_awvalid,
   input  logic [dram_dma_pkg::num_chan-1:0] scrb_awready,

   input  logic                              rd_in_valid,
   input  dram_dma_pkg::rdata_t              rd_in_data,
   input  dram_dma_pkg::id_t                 rd_in_id,
   input  logic                              rd_in_last,
   output logic                              rd_in_ready,
   output logic                              rd_out_valid,
   output dram_dma_pkg::rdata_t              rd_out_data,
   output dram_dma_pkg::id_t                 rd_out_id,
   output logic                              rd_out_last,
   input  logic                              rd_out_ready
);

   logic blk_rst_n;

   scrub_if scrb_bus [dram_dma_pkg::num_chan] ();

   reset_flr_ctrl #(
      .rst_stages (rst_stages)
   ) u_reset_flr_ctrl (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .flr_req    (flr_req),
      .blk_rst_n  (blk_rst_n),
      .flr_ack    (flr_ack)
   );

   // ------------------------------
   // One scrubber per DRAM channel
   // ------------------------------
   for (genvar i = 0; i < dram_dma_pkg::num_chan; i++)
   begin : g_scrb
      mem_scrubber #(
         .scrb_max_addr         (scrb_max_addr),
         .scrb_burst_len_minus1 (scrb_burst_len_minus1)
      ) u_mem_scrubber (
         .clk     (clk),
         .rst_n   (blk_rst_n),
         .scrb    (scrb_bus[i]),
         .awaddr  (scrb_awaddr[i]),
         .awvalid (scrb_awvalid[i]),
         .awready (scrb_awready[i])
      );
   end

   scrub_ctrl_regs u_scrub_ctrl_regs (
      .clk          (clk),
      .rst_n        (blk_rst_n),
      .ctl0         (ctl0),
      .ddr_is_ready (ddr_is_ready),
      .scrb         (scrb_bus),
      .status0      (status0),
      .id0          (id0),
      .id1          (id1)
   );

   // DMA read-return lane multiply
   rdata_lane_mult u_rdata_lane_mult (
      .clk       (clk),
      .rst_n     (blk_rst_n),
      .in_valid  (rd_in_valid),
      .in_data   (rd_in_data),
      .in_id     (rd_in_id),
      .in_last   (rd_in_last),
      .in_ready  (rd_in_ready),
      .out_valid (rd_out_valid),
      .out_data  (rd_out_data),
      .out_id    (rd_out_id),
      .out_last  (rd_out_last),
      .out_ready (rd_out_ready)
   );

endmodule

// File: tb/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ------------------------------
// Compare tasks
// ------------------------------
task automatic mismatch(string name, string exp, string act);
   errors++;
   $display("[FAIL] %0t ns %s expected %s actual %s", $time, name, exp, act);
endtask

task automatic fail_plain(string what);
   errors++;
   $display("ERROR at %0t ns: %s", $time, what);
endtask

task automatic check_status(string name, dram_dma_pkg::status_word_u exp,
                            dram_dma_pkg::status_word_u act);
   checks++;
   if (act !== exp)
      mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_addr(string name, dram_dma_pkg::addr_t exp, dram_dma_pkg::addr_t act);
   checks++;
   if (act !== exp)
      mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_rdata(string name, dram_dma_pkg::rdata_t exp, dram_dma_pkg::rdata_t act);
   checks++;
   if (act !== exp)
      mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_id(string name, dram_dma_pkg::id_t exp, dram_dma_pkg::id_t act);
   checks++;
   if (act !== exp)
      mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_bit(string name, logic exp, logic act);
   checks++;
   if (act !== exp)
      mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
endtask

// ------------------------------
// Random source
// ------------------------------
// Taps 32, 22, 2 and 1, one step per bit taken
function automatic logic [31:0] rand_bits(int n);
   logic [31:0] v;
   logic        fb;
   v = '0;
   for (int i = 0; i < n; i++)
   begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      v          = {v[30:0], lfsr_state[31]};
      lfsr_state = {lfsr_state[30:0], fb};
   end
   return v;
endfunction

function automatic dram_dma_pkg::rdata_t rand_word();
   dram_dma_pkg::rdata_t w;
   for (int i = 0; i < dram_dma_pkg::lanes * 2; i++)
      w[i*32 +: 32] = rand_bits(32);
   return w;
endfunction

// ------------------------------
// Reference models
// ------------------------------
function automatic dram_dma_pkg::status_word_u status_normal(logic [3:0] done_bits,
                                                             logic [3:0] ready_bits);
   dram_dma_pkg::status_word_u s;
   s = {dram_dma_pkg::status_sig, 4'hf, done_bits, ready_bits};
   return s;
endfunction

// Finished channels report done, the others idle
function automatic dram_dma_pkg::status_word_u status_debug(logic [3:0] done_bits,
                                                            logic [3:0] ready_bits);
   dram_dma_pkg::status_word_u s;
   logic [15:0]                chans;
   for (int c = 0; c < 4; c++)
      chans[c*4 +: 4] = done_bits[c] ? 4'h2 : 4'h0;
   s = {chans, 4'h0, 4'hf, done_bits, ready_bits};
   return s;
endfunction

function automatic dram_dma_pkg::rdata_t lane_product(dram_dma_pkg::rdata_t d);
   dram_dma_pkg::rdata_t p;
   logic [63:0]          hi;
   logic [63:0]          lo;
   for (int i = 0; i < dram_dma_pkg::lanes; i++)
   begin
      hi            = {32'h0, d[i*64+32 +: 32]};
      lo            = {32'h0, d[i*64 +: 32]};
      p[i*64 +: 64] = hi * lo;
   end
   return p;
endfunction

`endif

// File: tb/tb_dram_dma.sv
`timescale 1ns/1ns

module tb_dram_dma;

   typedef struct packed
   {
      logic       stall;
      logic [3:0] mask;
   } scrub_row_t;

   typedef struct packed
   {
      logic       en;
      logic [2:0] sel;
   } dbg_row_t;

   typedef struct packed
   {
      logic [7:0] words;
      logic       stall;
   } lane_row_t;

   localparam int n_ready    = 4;
   localparam int n_flr      = 3;
   localparam int n_scrub    = 4;
   localparam int n_dbg      = 7;
   localparam int n_lane     = 3;
   localparam int total_rows = n_ready + n_flr + n_scrub + n_dbg + n_lane;

   // Sweep ends at 1FFF in bursts of 16 beats of 64 bytes
   localparam int burst_bytes = 16 * 64;
   localparam int num_bursts  = 8192 / burst_bytes;

   logic [3:0] ready_tab    [n_ready] = '{4'h0, 4'h5, 4'hf, 4'h9};
   int         flr_hold_tab [n_flr]   = '{1, 4, 9};
   scrub_row_t scrub_tab    [n_scrub] = '{'{1'b0, 4'b0001}, '{1'b1, 4'b0110},
                                          '{1'b1, 4'b1111}, '{1'b1, 4'b1011}};
   dbg_row_t   dbg_tab      [n_dbg]   = '{'{1'b1, 3'd0}, '{1'b1, 3'd1}, '{1'b1, 3'd2},
                                          '{1'b1, 3'd3}, '{1'b1, 3'd6}, '{1'b0, 3'd1},
                                          '{1'b1, 3'd3}};
   lane_row_t  lane_tab     [n_lane]  = '{'{8'd12, 1'b0}, '{8'd24, 1'b1}, '{8'd16, 1'b1}};

   logic                              clk = 1'b0;
   logic                              sync_rst_n;
   logic                              flr_req;
   logic                              flr_ack;
   dram_dma_pkg::ctl_word_t           ctl0;
   logic [3:0]                        ddr_is_ready;
   dram_dma_pkg::status_word_u        status0;
   logic [31:0]                       id0;
   logic [31:0]                       id1;
   dram_dma_pkg::addr_t               scrb_awaddr [dram_dma_pkg::num_chan];
   logic [3:0]                        scrb_awvalid;
   logic [3:0]                        scrb_awready;
   logic                              rd_in_valid;
   dram_dma_pkg::rdata_t              rd_in_data;
   dram_dma_pkg::id_t                 rd_in_id;
   logic                              rd_in_last;
   logic                              rd_in_ready;
   logic                              rd_out_valid;
   dram_dma_pkg::rdata_t              rd_out_data;
   dram_dma_pkg::id_t                 rd_out_id;
   logic                              rd_out_last;
   logic                              rd_out_ready;

   int          errors;
   int          checks;
   int          tests_run;
   int          tests_bad;
   logic [31:0] lfsr_state;

   `include "tb_checks.svh"

   always #20 clk = ~clk;

   dram_dma_top #(
      .rst_stages            (4),
      .scrb_max_addr         (64'h1FFF),
      .scrb_burst_len_minus1 (15)
   ) u_dram_dma_top (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .flr_req      (flr_req),
      .flr_ack      (flr_ack),
      .ctl0         (ctl0),
      .ddr_is_ready (ddr_is_ready),
      .status0      (status0),
      .id0          (id0),
      .id1          (id1),
      .scrb_awaddr  (scrb_awaddr),
      .scrb_awvalid (scrb_awvalid),
      .scrb_awready (scrb_awready),
      .rd_in_valid  (rd_in_valid),
      .rd_in_data   (rd_in_data),
      .rd_in_id     (rd_in_id),
      .rd_in_last   (rd_in_last),
      .rd_in_ready  (rd_in_ready),
      .rd_out_valid (rd_out_valid),
      .rd_out_data  (rd_out_data),
      .rd_out_id    (rd_out_id),
      .rd_out_last  (rd_out_last),
      .rd_out_ready (rd_out_ready)
   );

   task automatic report_test(string name, int err_start);
      tests_run++;
      if (errors == err_start)
         $display("Test %-16s ok", name);
      else
      begin
         tests_bad++;
         $display("Test %-16s %0d errors", name, errors - err_start);
      end
   endtask

   task automatic wait_ack(logic level);
      int n;
      n = 0;
      while (flr_ack !== level && n < 8)
      begin
         @(negedge clk);
         n++;
      end
      if (flr_ack !== level)
         fail_plain($sformatf("flr_ack did not go to %b after flr_req changed", level));
   endtask

   task automatic run_flr(int hold);
      @(posedge clk);
      flr_req <= 1'b1;
      wait_ack(1'b1);
      repeat (hold)
      begin
         @(negedge clk);
         check_bit("flr_ack", 1'b1, flr_ack);
      end
      @(posedge clk);
      flr_req <= 1'b0;
      wait_ack(1'b0);
   endtask

   // ------------------------------
   // Scrubber sweep per table row
   // ------------------------------
   task automatic run_scrub(scrub_row_t row);
      int count [dram_dma_pkg::num_chan];
      int cyc;
      for (int c = 0; c < 4; c++)
         count[c] = 0;
      cyc = 0;
      // Drop all enables first so every channel restarts from 0
      @(posedge clk);
      ctl0         <= '0;
      scrb_awready <= '0;
      repeat (4) @(posedge clk);
      ctl0 <= {28'h0, row.mask};
      while (status0.norm.done !== row.mask && cyc < 400)
      begin
         @(posedge clk);
         scrb_awready <= row.stall ? 4'(rand_bits(4)) : 4'hf;
         @(negedge clk);
         for (int c = 0; c < 4; c++)
         begin
            if (scrb_awvalid[c] && !row.mask[c])
               fail_plain($sformatf("disabled channel %0d raised scrb_awvalid", c));
            else if (scrb_awvalid[c] && scrb_awready[c])
            begin
               if (count[c] >= num_bursts)
                  fail_plain($sformatf("channel %0d issued an extra burst", c));
               else
                  check_addr($sformatf("scrb_awaddr[%0d]", c),
                             dram_dma_pkg::addr_t'(count[c] * burst_bytes), scrb_awaddr[c]);
               count[c]++;
            end
         end
         cyc++;
      end
      if (status0.norm.done !== row.mask)
         fail_plain($sformatf("sweep with mask %b never showed its done bits", row.mask));
      for (int c = 0; c < 4; c++)
         if (count[c] != (row.mask[c] ? num_bursts : 0))
            fail_plain($sformatf("channel %0d sent %0d bursts", c, count[c]));
   endtask

   // ------------------------------
   // Lane multiply stream per row
   // ------------------------------
   task automatic run_lanes(lane_row_t row);
      dram_dma_pkg::rdata_t exp_data [$];
      dram_dma_pkg::id_t    exp_id   [$];
      logic                 exp_last [$];
      dram_dma_pkg::rdata_t word;
      dram_dma_pkg::id_t    id;
      logic                 last;
      int                   sent;
      int                   accepted;
      int                   got;
      int                   cyc;
      logic                 in_take;
      logic                 full;
      sent     = 0;
      accepted = 0;
      got      = 0;
      cyc      = 0;
      in_take  = 1'b0;
      while (got < row.words && cyc < row.words * 20)
      begin
         @(posedge clk);
         if (!rd_in_valid || in_take)
         begin
            if (sent < row.words)
            begin
               word = rand_word();
               id   = dram_dma_pkg::id_t'(rand_bits(6));
               last = 1'(rand_bits(1));
               rd_in_valid <= 1'b1;
               rd_in_data  <= word;
               rd_in_id    <= id;
               rd_in_last  <= last;
               exp_data.push_back(lane_product(word));
               exp_id.push_back(id);
               exp_last.push_back(last);
               sent++;
            end
            else
               rd_in_valid <= 1'b0;
         end
         rd_out_ready <= row.stall ? 1'(rand_bits(1)) : 1'b1;
         @(negedge clk);
         // Stage holds a word while more went in than came out
         full = (accepted > got);
         check_bit("rd_out_valid", full, rd_out_valid);
         check_bit("rd_in_ready", !(full && !rd_out_ready), rd_in_ready);
         in_take = rd_in_valid && rd_in_ready;
         if (in_take)
            accepted++;
         if (rd_out_valid && rd_out_ready)
         begin
            if (exp_data.size() == 0)
               fail_plain("rd_out_valid with no word pending");
            else
            begin
               check_rdata("rd_out_data", exp_data.pop_front(), rd_out_data);
               check_id("rd_out_id", exp_id.pop_front(), rd_out_id);
               check_bit("rd_out_last", exp_last.pop_front(), rd_out_last);
            end
            got++;
         end
         cyc++;
      end
      if (got != row.words)
         fail_plain($sformatf("only %0d of %0d read words came out", got, row.words));
      // Nothing may follow the last word
      @(posedge clk);
      rd_in_valid  <= 1'b0;
      rd_out_ready <= 1'b1;
      repeat (3)
      begin
         @(negedge clk);
         check_bit("rd_out_valid", 1'b0, rd_out_valid);
      end
   endtask

   initial
   begin
      int err_start;
      dram_dma_pkg::addr_t exp_addr;
      logic [3:0]          fin_mask;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_bad    = 0;
      lfsr_state   = 32'hac5f_13f1;
      sync_rst_n   = 1'b0;
      flr_req      = 1'b0;
      ctl0         = '0;
      ddr_is_ready = '0;
      scrb_awready = '0;
      rd_in_valid  = 1'b0;
      rd_in_data   = '0;
      rd_in_id     = '0;
      rd_in_last   = 1'b0;
      rd_out_ready = 1'b0;

      // Reset values followed by the normal status view
      err_start = errors;
      repeat (16) @(posedge clk);
      @(negedge clk);
      check_bit("flr_ack", 1'b0, flr_ack);
      check_bit("rd_out_valid", 1'b0, rd_out_valid);
      for (int c = 0; c < 4; c++)
         check_bit($sformatf("scrb_awvalid[%0d]", c), 1'b0, scrb_awvalid[c]);
      check_status("status0", '0, status0);
      check_addr("id1:id0", '0, {id1, id0});
      @(posedge clk);
      sync_rst_n <= 1'b1;
      repeat (8) @(posedge clk);
      for (int r = 0; r < n_ready; r++)
      begin
         ddr_is_ready <= ready_tab[r];
         repeat (3) @(posedge clk);
         @(negedge clk);
         check_status("status0", status_normal(4'h0, ready_tab[r]), status0);
         @(posedge clk);
      end
      report_test("reset_status", err_start);

      err_start = errors;
      for (int r = 0; r < n_flr; r++)
         run_flr(flr_hold_tab[r]);
      report_test("flr_handshake", err_start);

      err_start = errors;
      for (int r = 0; r < n_scrub; r++)
         run_scrub(scrub_tab[r]);
      report_test("scrub_sweep", err_start);

      // Channels of the last sweep stay done while the debug rows run
      err_start = errors;
      fin_mask  = scrub_tab[n_scrub-1].mask;
      for (int r = 0; r < n_dbg; r++)
      begin
         @(posedge clk);
         ctl0 <= {dbg_tab[r].en, dbg_tab[r].sel, 24'h0, fin_mask};
         repeat (3) @(posedge clk);
         @(negedge clk);
         exp_addr = (fin_mask[dbg_tab[r].sel < 4 ? dbg_tab[r].sel : 0]) ?
                    dram_dma_pkg::addr_t'(num_bursts * burst_bytes) : '0;
         if (dbg_tab[r].en)
         begin
            check_status("status0", status_debug(fin_mask, ready_tab[n_ready-1]), status0);
            check_addr("id1:id0", exp_addr, {id1, id0});
         end
         else
         begin
            check_status("status0", status_normal(fin_mask, ready_tab[n_ready-1]), status0);
            check_addr("id1:id0", {dram_dma_pkg::id1_default, dram_dma_pkg::id0_default},
                       {id1, id0});
         end
      end
      report_test("debug_view", err_start);

      err_start = errors;
      for (int r = 0; r < n_lane; r++)
         run_lanes(lane_tab[r]);
      report_test("lane_multiply", err_start);

      $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
               tests_run, tests_bad, checks, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // Watchdog allows 200 cycles per table row
   initial
   begin
      repeat (total_rows * 200) @(posedge clk);
      $display("Watchdog expired after %0d cycles, run stopped", total_rows * 200);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+tb
hw/dram_dma_pkg.sv
hw/scrub_if.sv
hw/reset_flr_ctrl.sv
hw/mem_scrubber.sv
hw/scrub_ctrl_regs.sv
hw/rdata_lane_mult.sv
hw/dram_dma_top.sv
tb/tb_dram_dma.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_dram_dma
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
